// ==== project.f ====
+incdir+src
src/vic_gfx_pkg.sv
src/vic_sprite_pkg.sv
src/gfx_stage_if.sv
src/gfx_shifter.sv
src/gfx_color_mux.sv
src/sprite_priority_mixer.sv
src/pixel_sequencer.sv
verif/pixel_sequencer_asserts.sv
verif/tb_pixel_sequencer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pixel_sequencer
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_pixel_sequencer.sv ====
`timescale 1ns/1ps

`include "vic_settings.svh"

module tb_pixel_sequencer import vic_gfx_pkg::*, vic_sprite_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int FILL_DOTS    = 24;
    localparam int SAMPLE_DOTS  = 16;
    // 2 std char, 5 mc char, 9 bitmap/ecm, 3 invalid, 8 sprite, 2 border
    localparam int NUM_CASES    = 29;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 200 +
                                    NUM_CASES * (FILL_DOTS + SAMPLE_DOTS) * `DOT_PHASES;

    logic                      clk_dot4x;
    logic                      rst;
    logic                      dot_rising_0_i       = 1'b0;
    logic                      clk_phi_i            = 1'b0;
    logic                      phi_phase_start_15_i = 1'b0;
    logic [2:0]                xpos_mod_8_i         = 3'd0;
    logic [6:0]                cycle_num_i;
    logic [2:0]                xscroll_i;
    gfx_mode_t                 mode_i;
    logic [7:0]                pixels_read_i;
    char_word_u                char_read_i;
    color_t                    b0c_i;
    color_t                    b1c_i;
    color_t                    b2c_i;
    color_t                    b3c_i;
    logic [2*`NUM_SPRITES-1:0] spr_pix_i;
    logic [6*`NUM_SPRITES-1:0] spr_attr_i;
    color_t                    spr_mc0_i;
    color_t                    spr_mc1_i;
    logic                      main_border_i;
    color_t                    ec_i;
    color_t                    pixel_color_o;
    logic                      is_background_o;

    // clock phase inside one phi period, 32 clocks = 8 dots
    logic [4:0]  tick        = 5'd0;
    int          cycle_count = 0;
    logic [31:0] lcg_state   = 32'd1879;
    color_t      base;

    pixel_sequencer DUT (.*);

    initial begin
        clk_dot4x = 1'b0;
        forever #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;
    end

    // dot strobe on every fourth clock
    // phi half period of 4 dots, fetch data valid at the end of phi low
    always @(negedge clk_dot4x) begin
        tick                 = tick + 5'd1;
        dot_rising_0_i       = tick[1:0] == 2'd3;
        phi_phase_start_15_i = tick[3:0] == 4'd15;
        clk_phi_i            = tick[4];
        xpos_mod_8_i         = tick[4:2];
    end

    // run limit
    always @(posedge clk_dot4x) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    function automatic color_t random_color();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[27:24];
    endfunction

    // distinct colours around the random base
    function automatic color_t shade(input logic [3:0] k);
        return base + k;
    endfunction

    task automatic compare_color(input string name, input color_t exp, input color_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "colour mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic wait_dot();
        @(posedge clk_dot4x);
        while (!dot_rising_0_i) @(posedge clk_dot4x);
    endtask

    task automatic new_colors();
        base      = random_color();
        b0c_i     = shade(4'd1);
        b1c_i     = shade(4'd2);
        b2c_i     = shade(4'd3);
        b3c_i     = shade(4'd4);
        spr_mc0_i = shade(4'd5);
        spr_mc1_i = shade(4'd6);
        ec_i      = shade(4'd7);
    endtask

    task automatic set_gfx(input gfx_mode_t mode, input logic [7:0] pix, input char_word_u word);
        @(negedge clk_dot4x);
        mode_i        = mode;
        pixels_read_i = pix;
        char_read_i   = word;
    endtask

    task automatic set_sprite(input int n, input spr_pix_t pix, input color_t col,
                              input logic pri, input logic mc);
        spr_attr_t attr;
        attr.color = col;
        attr.pri   = pri;
        attr.mc    = mc;
        spr_pix_i[2*n +: 2]  = pix;
        spr_attr_i[6*n +: 6] = attr;
    endtask

    task automatic clear_sprites();
        spr_pix_i  = '0;
        spr_attr_i = '0;
    endtask

    // let the pipeline settle, then every dot must show the same pixel
    task automatic run_case(input string name, input color_t exp_color, input logic exp_bg);
        repeat (FILL_DOTS) wait_dot();
        repeat (SAMPLE_DOTS) begin
            wait_dot();
            @(negedge clk_dot4x);
            compare_color(name, exp_color, pixel_color_o);
            compare_flag({name, "_bg"}, exp_bg, is_background_o);
        end
    endtask

    task automatic test_std_char();
        color_t fg;
        new_colors();
        fg = shade(4'd9);
        set_gfx(MODE_STD_CHAR, 8'hff, {fg, 2'b00, 6'h00});
        run_case("std_char_fg", fg, 1'b0);
        set_gfx(MODE_STD_CHAR, 8'h00, {fg, 2'b00, 6'h00});
        run_case("std_char_bg", b0c_i, 1'b1);
    endtask

    task automatic test_mc_char();
        color_t fg;
        new_colors();
        fg = shade(4'd9);
        // bit 11 set, pairs of bits
        fg[3] = 1'b1;
        set_gfx(MODE_MC_CHAR, 8'h55, {fg, 2'b00, 6'h00});
        run_case("mc_char_01", b1c_i, 1'b1);
        set_gfx(MODE_MC_CHAR, 8'haa, {fg, 2'b00, 6'h00});
        run_case("mc_char_10", b2c_i, 1'b0);
        set_gfx(MODE_MC_CHAR, 8'hff, {fg, 2'b00, 6'h00});
        run_case("mc_char_11", {1'b0, fg[2:0]}, 1'b0);
        // bit 11 clear falls back to hires
        fg[3] = 1'b0;
        set_gfx(MODE_MC_CHAR, 8'hff, {fg, 2'b00, 6'h00});
        run_case("mc_char_hires_fg", fg, 1'b0);
        set_gfx(MODE_MC_CHAR, 8'h00, {fg, 2'b00, 6'h00});
        run_case("mc_char_hires_bg", b0c_i, 1'b1);
    endtask

    task automatic test_bitmap();
        color_t     n11;
        color_t     n74;
        color_t     n30;
        color_t     bgs [4];
        logic [1:0] sel;
        new_colors();
        n11    = shade(4'd9);
        n74    = shade(4'd10);
        n30    = shade(4'd11);
        bgs[0] = b0c_i;
        bgs[1] = b1c_i;
        bgs[2] = b2c_i;
        bgs[3] = b3c_i;
        set_gfx(MODE_STD_BITMAP, 8'hff, {n11, n74, n30});
        run_case("std_bitmap_set", n74, 1'b0);
        set_gfx(MODE_STD_BITMAP, 8'h00, {n11, n74, n30});
        run_case("std_bitmap_clear", n30, 1'b1);
        set_gfx(MODE_MC_BITMAP, 8'h55, {n11, n74, n30});
        run_case("mc_bitmap_01", n74, 1'b1);
        set_gfx(MODE_MC_BITMAP, 8'haa, {n11, n74, n30});
        run_case("mc_bitmap_10", n30, 1'b0);
        set_gfx(MODE_MC_BITMAP, 8'hff, {n11, n74, n30});
        run_case("mc_bitmap_11", n11, 1'b0);
        // char bits 7..6 pick the background register
        sel = 2'd0;
        repeat (4) begin
            set_gfx(MODE_EXT_BG, 8'h00, {n11, sel, 6'h15});
            run_case($sformatf("ext_bg_sel%0d", sel), bgs[sel], 1'b1);
            sel = sel + 2'd1;
        end
    endtask

    task automatic test_invalid();
        gfx_mode_t bad [3];
        int        i;
        new_colors();
        bad[0] = MODE_INV_EXT_MC_CHAR;
        bad[1] = MODE_INV_EXT_STD_BITMAP;
        bad[2] = MODE_INV_EXT_MC_BITMAP;
        for (i = 0; i < 3; i++) begin
            set_gfx(bad[i], 8'hff, {shade(4'd9), shade(4'd10), shade(4'd11)});
            run_case($sformatf("invalid_mode_%0d", bad[i]), `COLOR_BLACK, 1'b0);
        end
    endtask

    task automatic test_sprites();
        color_t fg;
        new_colors();
        fg = shade(4'd9);
        set_gfx(MODE_STD_CHAR, 8'h00, {fg, 2'b00, 6'h00});
        set_sprite(3, 2'b10, shade(4'd12), 1'b0, 1'b0);
        run_case("sprite_hires", shade(4'd12), 1'b1);
        set_sprite(3, 2'b01, shade(4'd12), 1'b0, 1'b1);
        run_case("sprite_mc0", spr_mc0_i, 1'b1);
        set_sprite(3, 2'b11, shade(4'd12), 1'b0, 1'b1);
        run_case("sprite_mc1", spr_mc1_i, 1'b1);
        clear_sprites();
        // behind foreground, visible over background only
        set_sprite(2, 2'b10, shade(4'd13), 1'b1, 1'b0);
        run_case("sprite_behind_on_bg", shade(4'd13), 1'b1);
        set_gfx(MODE_STD_CHAR, 8'hff, {fg, 2'b00, 6'h00});
        run_case("sprite_behind_on_fg", fg, 1'b0);
        clear_sprites();
        // overlap, lower number wins
        set_gfx(MODE_STD_CHAR, 8'h00, {fg, 2'b00, 6'h00});
        set_sprite(1, 2'b10, shade(4'd14), 1'b0, 1'b0);
        set_sprite(5, 2'b10, shade(4'd15), 1'b0, 1'b0);
        run_case("sprite_overlap", shade(4'd14), 1'b1);
        clear_sprites();
        // sprite 0 behind fg hides sprite 4 in front of it
        set_gfx(MODE_STD_CHAR, 8'hff, {fg, 2'b00, 6'h00});
        set_sprite(0, 2'b10, shade(4'd12), 1'b1, 1'b0);
        set_sprite(4, 2'b10, shade(4'd13), 1'b0, 1'b0);
        run_case("sprite_restore_fg", fg, 1'b0);
        clear_sprites();
        // same with a multicolour mc0 pixel as the hiding sprite
        set_sprite(0, 2'b01, shade(4'd12), 1'b1, 1'b1);
        set_sprite(4, 2'b10, shade(4'd13), 1'b0, 1'b0);
        run_case("sprite_mc_restore_fg", fg, 1'b0);
        clear_sprites();
    endtask

    task automatic test_border();
        color_t fg;
        new_colors();
        fg = shade(4'd9);
        set_gfx(MODE_STD_CHAR, 8'hff, {fg, 2'b00, 6'h00});
        main_border_i = 1'b1;
        run_case("border_gfx", ec_i, 1'b0);
        set_sprite(0, 2'b10, shade(4'd12), 1'b0, 1'b0);
        run_case("border_sprite", ec_i, 1'b0);
        @(negedge clk_dot4x);
        main_border_i = 1'b0;
        clear_sprites();
    endtask

    initial begin
        rst           = 1'b1;
        cycle_num_i   = 7'd20;
        xscroll_i     = 3'd0;
        mode_i        = MODE_STD_CHAR;
        pixels_read_i = 8'h00;
        char_read_i   = '0;
        b0c_i         = `COLOR_BLACK;
        b1c_i         = `COLOR_BLACK;
        b2c_i         = `COLOR_BLACK;
        b3c_i         = `COLOR_BLACK;
        spr_pix_i     = '0;
        spr_attr_i    = '0;
        spr_mc0_i     = `COLOR_BLACK;
        spr_mc1_i     = `COLOR_BLACK;
        main_border_i = 1'b0;
        ec_i          = `COLOR_BLACK;
        base          = `COLOR_BLACK;
        repeat (RESET_CYCLES) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        rst = 1'b0;
        test_std_char();
        test_mc_char();
        test_bitmap();
        test_invalid();
        test_sprites();
        test_border();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verif/pixel_sequencer_asserts.sv ====
`timescale 1ns/1ps

`include "vic_settings.svh"

module pixel_sequencer_asserts import vic_gfx_pkg::*; (
    input logic                      clk_dot4x,
    input logic                      rst,
    input gfx_mode_t                 mode_i,
    input logic [2*`NUM_SPRITES-1:0] spr_pix_i,
    input logic                      main_border_i,
    input color_t                    ec_i,
    input color_t                    pixel_color_i
);

    // output register cleared by reset
    property black_after_reset;
        @(posedge clk_dot4x) rst |=> pixel_color_i == `COLOR_BLACK;
    endproperty

    // border mask is the last register
    property border_next_clock;
        @(posedge clk_dot4x) disable iff (rst)
            main_border_i |=> pixel_color_i == $past(ec_i);
    endproperty

    // mode reaches the mix one clock early, sprites sit one dot in spr_q
    property invalid_mode_black;
        @(posedge clk_dot4x) disable iff (rst)
            (mode_is_invalid($past(mode_i)) && !main_border_i &&
             $past(spr_pix_i, 2) == '0 && $past(spr_pix_i, 3) == '0 &&
             $past(spr_pix_i, 4) == '0 && $past(spr_pix_i, 5) == '0)
            |=> pixel_color_i == `COLOR_BLACK;
    endproperty

    assert property (black_after_reset)
        else $error("pixel colour is not black after reset");
    assert property (border_next_clock)
        else $error("border colour did not appear one clock after main border");
    assert property (invalid_mode_black)
        else $error("invalid mode shows a non-black pixel without sprite or border");

endmodule

bind pixel_sequencer pixel_sequencer_asserts u_asserts (
    .clk_dot4x     (clk_dot4x),
    .rst           (rst),
    .mode_i        (mode_i),
    .spr_pix_i     (spr_pix_i),
    .main_border_i (main_border_i),
    .ec_i          (ec_i),
    .pixel_color_i (pixel_color_o)
);

// ==== src/pixel_sequencer.sv ====
`timescale 1ns/1ps

`include "vic_settings.svh"

module pixel_sequencer import vic_gfx_pkg::*, vic_sprite_pkg::*; (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  logic                        dot_rising_0_i,
    input  logic                        clk_phi_i,
    input  logic                        phi_phase_start_15_i,
    input  logic [6:0]                  cycle_num_i,
    input  logic [2:0]                  xscroll_i,
    input  logic [2:0]                  xpos_mod_8_i,
    input  gfx_mode_t                   mode_i,
    input  logic [7:0]                  pixels_read_i,
    input  char_word_u                  char_read_i,
    input  color_t                      b0c_i,
    input  color_t                      b1c_i,
    input  color_t                      b2c_i,
    input  color_t                      b3c_i,
    input  logic [2*`NUM_SPRITES-1:0]   spr_pix_i,
    input  logic [6*`NUM_SPRITES-1:0]   spr_attr_i,
    input  color_t                      spr_mc0_i,
    input  color_t                      spr_mc1_i,
    input  logic                        main_border_i,
    input  color_t                      ec_i,
    output color_t                      pixel_color_o,
    output logic                        is_background_o
);

    gfx_stage_if stage_bus ();

    spr_pix_t  spr_pix  [`NUM_SPRITES];
    spr_attr_t spr_attr [`NUM_SPRITES];
    color_t    gfx_color;
    logic      gfx_is_bg;

    // sprite n sits at the low end, n = 0 in the lowest slice
    always_comb begin
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            spr_pix[n]  = spr_pix_i[2*n +: 2];
            spr_attr[n] = spr_attr_i[6*n +: 6];
        end
    end

    gfx_shifter u_shifter (
        .clk_dot4x            (clk_dot4x),
        .rst                  (rst),
        .dot_rising_0_i       (dot_rising_0_i),
        .clk_phi_i            (clk_phi_i),
        .phi_phase_start_15_i (phi_phase_start_15_i),
        .cycle_num_i          (cycle_num_i),
        .xscroll_i            (xscroll_i),
        .xpos_mod_8_i         (xpos_mod_8_i),
        .mode_i               (mode_i),
        .pixels_read_i        (pixels_read_i),
        .char_read_i          (char_read_i),
        .stage                (stage_bus.shifter)
    );

    gfx_color_mux u_color_mux (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .dot_rising_0_i (dot_rising_0_i),
        .mode_i         (mode_i),
        .b0c_i          (b0c_i),
        .b1c_i          (b1c_i),
        .b2c_i          (b2c_i),
        .b3c_i          (b3c_i),
        .stage          (stage_bus.mux),
        .color_o        (gfx_color),
        .is_bg_o        (gfx_is_bg)
    );

    sprite_priority_mixer u_mixer (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .dot_rising_0_i (dot_rising_0_i),
        .mode_i         (mode_i),
        .color_i        (gfx_color),
        .is_bg_i        (gfx_is_bg),
        .spr_pix_i      (spr_pix),
        .spr_attr_i     (spr_attr),
        .spr_mc0_i      (spr_mc0_i),
        .spr_mc1_i      (spr_mc1_i),
        .main_border_i  (main_border_i),
        .ec_i           (ec_i),
        .pixel_color_o  (pixel_color_o)
    );

    // background flag of the pixel now leaving the shifter
    assign is_background_o = stage_bus.is_bg;

endmodule

// ==== src/sprite_priority_mixer.sv ====
`timescale 1ns/1ps

`include "vic_settings.svh"

module sprite_priority_mixer import vic_gfx_pkg::*, vic_sprite_pkg::*; (
    input  logic      clk_dot4x,
    input  logic      rst,
    input  logic      dot_rising_0_i,
    input  gfx_mode_t mode_i,
    input  color_t    color_i,
    input  logic      is_bg_i,
    input  spr_pix_t  spr_pix_i [`NUM_SPRITES],
    input  spr_attr_t spr_attr_i [`NUM_SPRITES],
    input  color_t    spr_mc0_i,
    input  color_t    spr_mc1_i,
    input  logic      main_border_i,
    input  color_t    ec_i,
    output color_t    pixel_color_o
);

    spr_pix_t spr_q [`NUM_SPRITES];
    color_t   gfx_color;
    color_t   mix_color;
    color_t   mix_q;

    // sprite pixels one dot late, same schedule as is_bg_i
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                spr_q[n] <= 2'b00;
            end
        end else if (dot_rising_0_i) begin
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                spr_q[n] <= spr_pix_i[n];
            end
        end
    end

    // invalid modes blank graphics, sprites still show
    assign gfx_color = mode_is_invalid(mode_i) ? `COLOR_BLACK : color_i;

    // walk 7 down to 0 so the lowest sprite is written last
    always_comb begin
        mix_color = gfx_color;
        for (int n = `NUM_SPRITES - 1; n >= 0; n--) begin
            if (!spr_attr_i[n].pri || is_bg_i) begin
                if (spr_attr_i[n].mc) begin
                    case (spr_q[n])
                        2'b01:   mix_color = spr_mc0_i;
                        2'b10:   mix_color = spr_attr_i[n].color;
                        2'b11:   mix_color = spr_mc1_i;
                        default: mix_color = mix_color;
                    endcase
                end else if (spr_q[n][1]) begin
                    mix_color = spr_attr_i[n].color;
                end
            end
            // behind-fg sprite over foreground undoes lower sprites
            // any multicolour code other than 00 is an opaque pixel
            if (spr_attr_i[n].pri && !is_bg_i &&
                (spr_attr_i[n].mc ? spr_q[n] != 2'b00 : spr_q[n][1])) begin
                mix_color = gfx_color;
            end
        end
    end

    // mix then border, one clock each
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            mix_q         <= `COLOR_BLACK;
            pixel_color_o <= `COLOR_BLACK;
        end else begin
            mix_q         <= mix_color;
            pixel_color_o <= main_border_i ? ec_i : mix_q;
        end
    end

endmodule

// ==== src/gfx_color_mux.sv ====
`timescale 1ns/1ps

`include "vic_settings.svh"

module gfx_color_mux import vic_gfx_pkg::*; (
    input  logic      clk_dot4x,
    input  logic      rst,
    input  logic      dot_rising_0_i,
    input  gfx_mode_t mode_i,
    input  color_t    b0c_i,
    input  color_t    b1c_i,
    input  color_t    b2c_i,
    input  color_t    b3c_i,
    gfx_stage_if.mux  stage,
    output color_t    color_o,
    output logic      is_bg_o
);

    color_t       next_color;
    color_t       hires_char;
    char_text_t   txt;
    char_bitmap_t bmp;

    assign txt = stage.char_word.text;
    assign bmp = stage.char_word.bitmap;

    // hires text, shared by std char and mc char with fg bit 3 clear
    assign hires_char = stage.pix_top[1] ? txt.fg : b0c_i;

    // invalid modes share the rule of their legal neighbour
    always_comb begin
        case (mode_i)
            MODE_STD_CHAR: begin
                next_color = hires_char;
            end
            MODE_MC_CHAR, MODE_INV_EXT_MC_CHAR: begin
                if (stage.is_mc) begin
                    case (stage.pix_top)
                        2'b00:   next_color = b0c_i;
                        2'b01:   next_color = b1c_i;
                        2'b10:   next_color = b2c_i;
                        // only 8 colours, bit 3 is the mc flag
                        default: next_color = {1'b0, txt.fg[2:0]};
                    endcase
                end else begin
                    next_color = hires_char;
                end
            end
            MODE_STD_BITMAP, MODE_INV_EXT_STD_BITMAP: begin
                // set pixel takes the upper screen nibble
                next_color = stage.pix_top[1] ? bmp.col_01 : bmp.col_10;
            end
            MODE_MC_BITMAP, MODE_INV_EXT_MC_BITMAP: begin
                case (stage.pix_top)
                    2'b00:   next_color = b0c_i;
                    2'b01:   next_color = bmp.col_01;
                    2'b10:   next_color = bmp.col_10;
                    default: next_color = bmp.col_11;
                endcase
            end
            MODE_EXT_BG: begin
                // char code bits 7..6 choose one of four backgrounds
                if (stage.pix_top[1]) begin
                    next_color = txt.fg;
                end else begin
                    case (txt.bg_sel)
                        2'b00:   next_color = b0c_i;
                        2'b01:   next_color = b1c_i;
                        2'b10:   next_color = b2c_i;
                        default: next_color = b3c_i;
                    endcase
                end
            end
            default: begin
                next_color = `COLOR_BLACK;
            end
        endcase
    end

    // bg flag delayed one dot to meet the delayed sprite pixels
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            color_o <= `COLOR_BLACK;
            is_bg_o <= 1'b0;
        end else if (dot_rising_0_i) begin
            color_o <= next_color;
            is_bg_o <= stage.is_bg;
        end
    end

endmodule

// ==== src/gfx_shifter.sv ====
`timescale 1ns/1ps

`include "vic_settings.svh"

module gfx_shifter import vic_gfx_pkg::*; (
    input  logic       clk_dot4x,
    input  logic       rst,
    input  logic       dot_rising_0_i,
    input  logic       clk_phi_i,
    input  logic       phi_phase_start_15_i,
    input  logic [6:0] cycle_num_i,
    input  logic [2:0] xscroll_i,
    input  logic [2:0] xpos_mod_8_i,
    input  gfx_mode_t  mode_i,
    input  logic [7:0] pixels_read_i,
    input  char_word_u char_read_i,
    gfx_stage_if.shifter stage
);

    // [0] is the capture slot, the rest ages one per dot
    logic [7:0] pix_dly  [`XPOS_GFX_DELAY+1];
    char_word_u char_dly [`XPOS_GFX_DELAY+1];
    logic [2:0] xscroll_q;

    logic [7:0] pix_q;
    char_word_u char_q;
    logic       shift_q;
    logic       bg_q;

    logic [2:0] mode_bits;
    logic       capture;
    logic       load;
    logic       is_mc;
    logic       load_mc;

    // {ecm, bmm, mcm}
    assign mode_bits = mode_i;

    // end of phi low, fetch data is stable
    assign capture = !clk_phi_i && phi_phase_start_15_i;

    assign load = xpos_mod_8_i == xscroll_q;

    // bitmap and ecm force pairs whenever mcm is set, text asks the char
    assign is_mc   = mode_bits[0] & (mode_bits[2] | mode_bits[1] | char_q.text.fg[3]);
    assign load_mc = mode_bits[0] &
                     (mode_bits[2] | mode_bits[1] | char_dly[`XPOS_GFX_DELAY].text.fg[3]);

    always_ff @(posedge clk_dot4x) begin
        if (capture) begin
            pix_dly[0]  <= pixels_read_i;
            char_dly[0] <= char_read_i;
        end
        if (dot_rising_0_i) begin
            for (int n = `XPOS_GFX_DELAY; n > 0; n--) begin
                pix_dly[n]  <= pix_dly[n-1];
                char_dly[n] <= char_dly[n-1];
            end
        end
    end

    // scroll only follows the register inside the display cycles
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            xscroll_q <= 3'd0;
        end else if (capture && cycle_num_i >= 7'd15 && cycle_num_i <= 7'd55) begin
            xscroll_q <= xscroll_i;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pix_q   <= 8'd0;
            char_q  <= '0;
            shift_q <= 1'b0;
            bg_q    <= 1'b0;
        end else if (dot_rising_0_i) begin
            if (load) begin
                pix_q  <= pix_dly[`XPOS_GFX_DELAY];
                char_q <= char_dly[`XPOS_GFX_DELAY];
                // multicolour holds the first pair for two dots
                shift_q <= !load_mc;
                bg_q    <= !pix_dly[`XPOS_GFX_DELAY][7];
            end else begin
                if (shift_q) begin
                    if (is_mc) begin
                        pix_q <= {pix_q[5:0], 2'b00};
                        bg_q  <= !pix_q[5];
                    end else begin
                        pix_q <= {pix_q[6:0], 1'b0};
                        bg_q  <= !pix_q[6];
                    end
                end
                // toggles in multicolour, stays set in hires
                shift_q <= is_mc ? !shift_q : shift_q;
            end
        end
    end

    assign stage.pix_top   = pix_q[7:6];
    assign stage.char_word = char_q;
    assign stage.is_mc     = is_mc;
    assign stage.is_bg     = bg_q;

endmodule

// ==== src/gfx_stage_if.sv ====
`timescale 1ns/1ps

interface gfx_stage_if import vic_gfx_pkg::*; ();

    // top two bits of the pixel shifter
    logic [1:0] pix_top;
    // char word belonging to the shifting byte
    char_word_u char_word;
    // current pixel is a multicolour pair
    logic       is_mc;
    // current pixel counts as background for sprite priority
    logic       is_bg;

    modport shifter (
        output pix_top,
        output char_word,
        output is_mc,
        output is_bg
    );

    modport mux (
        input pix_top,
        input char_word,
        input is_mc,
        input is_bg
    );

endinterface

// ==== src/vic_sprite_pkg.sv ====
package vic_sprite_pkg;

    // sprite pixel as delivered by the sprite sequencer
    // hires uses bit 1 only
    // multicolour 01 mc0, 10 own colour, 11 mc1
    typedef logic [1:0] spr_pix_t;

    // per-sprite register bits
    typedef struct packed {
        // own colour
        logic [3:0] color;
        // 1 = behind foreground graphics
        logic       pri;
        // multicolour enable
        logic       mc;
    } spr_attr_t;

endpackage

// ==== src/vic_gfx_pkg.sv ====
package vic_gfx_pkg;

    // palette index
    typedef logic [3:0] color_t;

    // encoded as {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        MODE_STD_CHAR           = 3'b000,
        MODE_MC_CHAR            = 3'b001,
        MODE_STD_BITMAP         = 3'b010,
        MODE_MC_BITMAP          = 3'b011,
        MODE_EXT_BG             = 3'b100,
        MODE_INV_EXT_MC_CHAR    = 3'b101,
        MODE_INV_EXT_STD_BITMAP = 3'b110,
        MODE_INV_EXT_MC_BITMAP  = 3'b111
    } gfx_mode_t;

    // text modes, colour ram nibble on top
    // fg bit 3 doubles as the multicolour enable per char
    typedef struct packed {
        color_t     fg;
        logic [1:0] bg_sel;
        logic [5:0] code_lo;
    } char_text_t;

    // bitmap modes, colour ram nibble plus screen byte
    typedef struct packed {
        color_t col_11;
        color_t col_01;
        color_t col_10;
    } char_bitmap_t;

    // one fetched word, decoded by mode
    typedef union packed {
        char_text_t   text;
        char_bitmap_t bitmap;
    } char_word_u;

    // ecm together with bmm or mcm has no legal meaning
    function automatic logic mode_is_invalid(gfx_mode_t mode);
        return mode inside {MODE_INV_EXT_MC_CHAR, MODE_INV_EXT_STD_BITMAP,
                            MODE_INV_EXT_MC_BITMAP};
    endfunction

endpackage

// ==== src/vic_settings.svh ====
`ifndef VIC_SETTINGS_SVH
`define VIC_SETTINGS_SVH

// sprite count of the chip
`define NUM_SPRITES 8

// dot strobes between fetch capture and the first possible shifter load
// the first pixel of a load then shows up one dot later
`define XPOS_GFX_DELAY 2

// palette index 0
`define COLOR_BLACK 4'h0

// clk_dot4x cycles per dot, one of them carries dot_rising_0
`define DOT_PHASES 4

`endif
